// ==== Bender.yml ====
package:
  name: llc_front

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/llc_pkg.sv
      - rtl/llc_channel_buf.sv
      - rtl/llc_input_decoder.sv
      - rtl/llc_stall_ctrl.sv
      - rtl/llc_tag_array.sv
      - rtl/llc_front.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/llc_front_assertions.sv
      - tb/llc_front_tb.sv

// ==== project.f ====
+incdir+rtl
rtl/llc_pkg.sv
rtl/llc_channel_buf.sv
rtl/llc_input_decoder.sv
rtl/llc_stall_ctrl.sv
rtl/llc_tag_array.sv
rtl/llc_front.sv
tb/llc_front_assertions.sv
tb/llc_front_tb.sv

// ==== rtl/llc_channel_buf.sv ====
`default_nettype none

module llc_channel_buf #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data,
    input  wire logic     take
);

    logic full;
    logic accept;

    assign accept   = in_valid && in_ready;
    assign in_ready = !full;   // one entry, no bypass.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    // payload held until the decoder takes it.
    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= in_data;
        end
    end

    assign out_valid = full;

endmodule

`default_nettype wire

// ==== rtl/llc_defines.svh ====
`ifndef LLC_DEFINES_SVH
`define LLC_DEFINES_SVH

`default_nettype none

// ==================================================
// address layout {tag, set, offset}
// ==================================================
`define LLC_SET_BITS    4
`define LLC_TAG_BITS    8
`define LLC_OFFSET_BITS 4   // byte within a line.

`define LLC_ADDR_BITS   (`LLC_TAG_BITS + `LLC_SET_BITS + `LLC_OFFSET_BITS)

`default_nettype wire

`endif

// ==== rtl/llc_front.sv ====
`default_nettype none

module llc_front (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              flush,
    input  wire logic              rsp_in_valid,
    output logic                   rsp_in_ready,
    input  wire llc_pkg::llc_rsp_t rsp_in_data,
    input  wire logic              req_in_valid,
    output logic                   req_in_ready,
    input  wire llc_pkg::llc_req_t req_in_data,
    input  wire logic              dma_in_valid,
    output logic                   dma_in_ready,
    input  wire llc_pkg::llc_dma_t dma_in_data,
    output logic                   lkp_valid,
    input  wire logic              lkp_ready,
    output llc_pkg::llc_lkp_res_t  lkp_res,
    output logic                   busy
);

    import llc_pkg::*;

    llc_rsp_t   rsp_data;
    llc_req_t   req_data;
    llc_dma_t   dma_data;
    logic       rsp_valid, req_valid, dma_valid;
    logic       rsp_take, req_take, dma_take;
    logic       look, walk_clear, hit, lkp_busy;
    llc_line_t  line, parked_line;
    llc_src_t   src;
    logic [3:0] id, parked_id;
    llc_set_t   walk_set;
    logic       rst_stall, flush_stall, req_stall, parked_valid;
    logic       incr_walk_set, clr_rst_stall, clr_flush_stall, clr_req_stall;
    logic       park, replay_taken;

    // ==================================================
    // input channels
    // ==================================================
    llc_channel_buf #(.payload_t(llc_rsp_t)) rsp_buf_i (
        .clk(clk), .rst(rst),
        .in_valid(rsp_in_valid), .in_ready(rsp_in_ready), .in_data(rsp_in_data),
        .out_valid(rsp_valid), .out_data(rsp_data), .take(rsp_take)
    );

    llc_channel_buf #(.payload_t(llc_req_t)) req_buf_i (
        .clk(clk), .rst(rst),
        .in_valid(req_in_valid), .in_ready(req_in_ready), .in_data(req_in_data),
        .out_valid(req_valid), .out_data(req_data), .take(req_take)
    );

    llc_channel_buf #(.payload_t(llc_dma_t)) dma_buf_i (
        .clk(clk), .rst(rst),
        .in_valid(dma_in_valid), .in_ready(dma_in_ready), .in_data(dma_in_data),
        .out_valid(dma_valid), .out_data(dma_data), .take(dma_take)
    );

    llc_input_decoder decoder_i (
        .clk(clk), .rst(rst),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data),
        .req_valid(req_valid), .req_data(req_data),
        .dma_valid(dma_valid), .dma_data(dma_data),
        .rst_stall(rst_stall), .flush_stall(flush_stall), .req_stall(req_stall),
        .parked_valid(parked_valid), .parked_line(parked_line), .parked_id(parked_id),
        .walk_set(walk_set), .hit(hit), .lkp_busy(lkp_busy),
        .rsp_take(rsp_take), .req_take(req_take), .dma_take(dma_take),
        .look(look), .walk_clear(walk_clear), .line(line), .src(src), .id(id),
        .incr_walk_set(incr_walk_set), .clr_rst_stall(clr_rst_stall),
        .clr_flush_stall(clr_flush_stall), .clr_req_stall(clr_req_stall),
        .park(park), .replay_taken(replay_taken)
    );

    llc_stall_ctrl stall_i (
        .clk(clk), .rst(rst), .flush(flush),
        .incr_walk_set(incr_walk_set), .clr_rst_stall(clr_rst_stall),
        .clr_flush_stall(clr_flush_stall), .clr_req_stall(clr_req_stall),
        .park(park), .park_line(line), .park_id(id), .replay_taken(replay_taken),
        .rst_stall(rst_stall), .flush_stall(flush_stall), .req_stall(req_stall),
        .walk_set(walk_set), .parked_valid(parked_valid), .parked_line(parked_line),
        .parked_id(parked_id), .busy(busy)
    );

    // shared tag store, owned by whichever source won the round.
    llc_tag_array tags_i (
        .clk(clk), .rst(rst),
        .look(look), .walk_clear(walk_clear), .line(line), .src(src), .id(id),
        .lkp_ready(lkp_ready), .hit(hit), .lkp_valid(lkp_valid),
        .lkp_res(lkp_res), .lkp_busy(lkp_busy)
    );

endmodule

`default_nettype wire

// ==== rtl/llc_input_decoder.sv ====
`include "llc_defines.svh"
`default_nettype none

module llc_input_decoder (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               rsp_valid,
    input  wire llc_pkg::llc_rsp_t  rsp_data,
    input  wire logic               req_valid,
    input  wire llc_pkg::llc_req_t  req_data,
    input  wire logic               dma_valid,
    input  wire llc_pkg::llc_dma_t  dma_data,
    input  wire logic               rst_stall,
    input  wire logic               flush_stall,
    input  wire logic               req_stall,
    input  wire logic               parked_valid,
    input  wire llc_pkg::llc_line_t parked_line,
    input  wire logic [3:0]         parked_id,
    input  wire llc_pkg::llc_set_t  walk_set,
    input  wire logic               hit,
    input  wire logic               lkp_busy,
    output logic                    rsp_take,
    output logic                    req_take,
    output logic                    dma_take,
    output logic                    look,
    output logic                    walk_clear,
    output llc_pkg::llc_line_t      line,
    output llc_pkg::llc_src_t       src,
    output logic [3:0]              id,
    output logic                    incr_walk_set,
    output logic                    clr_rst_stall,
    output logic                    clr_flush_stall,
    output logic                    clr_req_stall,
    output logic                    park,
    output logic                    replay_taken
);

    import llc_pkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        DECODE = 2'b01,
        SET    = 2'b11,
        STALL  = 2'b10
    } state_t;

    state_t state, next_state;

    logic sel_rst_walk, sel_flush_walk, sel_rsp, sel_req, sel_replay, sel_dma;
    logic rst_walk_q, flush_walk_q, rsp_q, req_q, replay_q, dma_q;
    logic walk_q, lookup_q, st_set, exit_stall, last_set;
    llc_line_t  line_next;
    llc_src_t   src_next;
    logic [3:0] id_next;

    function automatic llc_line_t addr_to_line(input llc_addr_t addr);
        llc_line_t l;
        l.tag = addr[`LLC_ADDR_BITS-1 -: `LLC_TAG_BITS];
        l.set = addr[`LLC_OFFSET_BITS +: `LLC_SET_BITS];
        return l;
    endfunction

    // ==================================================
    // round: IDLE, DECODE, SET, STALL
    // ==================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    next_state = DECODE;
            DECODE:  next_state = SET;
            SET:     next_state = STALL;
            STALL:   if (!lkp_busy) next_state = IDLE;   // hold until result taken.
            default: next_state = IDLE;
        endcase
    end

    // fixed priority, walks first.
    always_comb begin
        sel_rst_walk   = 1'b0;
        sel_flush_walk = 1'b0;
        sel_rsp        = 1'b0;
        sel_req        = 1'b0;
        sel_replay     = 1'b0;
        sel_dma        = 1'b0;
        line_next      = '0;
        src_next       = SRC_RSP;
        id_next        = '0;
        if (rst_stall || flush_stall) begin
            sel_rst_walk   = rst_stall;
            sel_flush_walk = !rst_stall;
            line_next.set  = walk_set;
        end else if (rsp_valid) begin
            sel_rsp   = 1'b1;
            line_next = addr_to_line(rsp_data.addr);
        end else if (!req_stall && parked_valid) begin
            sel_replay = 1'b1;   // parked request goes before new ones.
            line_next  = parked_line;
            src_next   = SRC_REPLAY;
            id_next    = parked_id;
        end else if (!req_stall && req_valid) begin
            sel_req   = 1'b1;
            line_next = addr_to_line(req_data.addr);
            src_next  = SRC_REQ;
            id_next   = req_data.id;
        end else if (!req_stall && dma_valid) begin
            sel_dma   = 1'b1;
            line_next = addr_to_line(dma_data.addr);
            src_next  = SRC_DMA;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_walk_q   <= 1'b0;
            flush_walk_q <= 1'b0;
            rsp_q        <= 1'b0;
            req_q        <= 1'b0;
            replay_q     <= 1'b0;
            dma_q        <= 1'b0;
        end else if (state == DECODE) begin
            rst_walk_q   <= sel_rst_walk;
            flush_walk_q <= sel_flush_walk;
            rsp_q        <= sel_rsp;
            req_q        <= sel_req;
            replay_q     <= sel_replay;
            dma_q        <= sel_dma;
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            line <= line_next;
            src  <= src_next;
            id   <= id_next;
        end
    end

    // ==================================================
    // SET and STALL outputs
    // ==================================================
    assign st_set     = (state == SET);
    assign exit_stall = (state == STALL) && !lkp_busy;
    assign walk_q     = rst_walk_q || flush_walk_q;
    assign lookup_q   = rsp_q || req_q || replay_q || dma_q;
    assign last_set   = (walk_set == {`LLC_SET_BITS{1'b1}});

    assign rsp_take     = st_set && rsp_q;
    assign req_take     = st_set && req_q;
    assign dma_take     = st_set && dma_q;
    assign replay_taken = st_set && replay_q;
    assign look         = st_set && lookup_q;
    assign walk_clear   = st_set && walk_q;

    assign incr_walk_set   = exit_stall && walk_q;
    assign clr_rst_stall   = exit_stall && rst_walk_q && last_set;
    assign clr_flush_stall = exit_stall && flush_walk_q && last_set;
    assign clr_req_stall   = exit_stall && rsp_q && req_stall && (line == parked_line);
    assign park            = exit_stall && (req_q || replay_q || dma_q) && !hit;

endmodule

`default_nettype wire

// ==== rtl/llc_pkg.sv ====
`include "llc_defines.svh"
`default_nettype none

package llc_pkg;

    typedef logic [`LLC_ADDR_BITS-1:0] llc_addr_t;
    typedef logic [`LLC_SET_BITS-1:0]  llc_set_t;
    typedef logic [`LLC_TAG_BITS-1:0]  llc_tag_t;

    // who issued a lookup.
    typedef enum logic [1:0] {
        SRC_RSP    = 2'd0,
        SRC_REQ    = 2'd1,
        SRC_DMA    = 2'd2,
        SRC_REPLAY = 2'd3
    } llc_src_t;

    // ==================================================
    // channel payloads
    // ==================================================
    typedef struct packed {
        llc_addr_t addr;
    } llc_rsp_t;

    typedef struct packed {
        llc_addr_t  addr;
        logic [3:0] id;
    } llc_req_t;

    typedef struct packed {
        llc_addr_t addr;
        logic      write;
    } llc_dma_t;

    // address split as the tag array sees it.
    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
    } llc_line_t;

    typedef struct packed {
        llc_src_t   src;
        logic       hit;   // state before the lookup, also for fills.
        llc_set_t   set;
        llc_tag_t   tag;
        logic [3:0] id;
    } llc_lkp_res_t;

endpackage

`default_nettype wire

// ==== rtl/llc_stall_ctrl.sv ====
`default_nettype none

module llc_stall_ctrl (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               flush,
    input  wire logic               incr_walk_set,
    input  wire logic               clr_rst_stall,
    input  wire logic               clr_flush_stall,
    input  wire logic               clr_req_stall,
    input  wire logic               park,
    input  wire llc_pkg::llc_line_t park_line,
    input  wire logic [3:0]         park_id,
    input  wire logic               replay_taken,
    output logic                    rst_stall,
    output logic                    flush_stall,
    output logic                    req_stall,
    output llc_pkg::llc_set_t       walk_set,
    output logic                    parked_valid,
    output llc_pkg::llc_line_t      parked_line,
    output logic [3:0]              parked_id,
    output logic                    busy
);

    // ==================================================
    // invalidate walks
    // ==================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall   <= 1'b1;   // power-on walk.
            flush_stall <= 1'b0;
            walk_set    <= '0;
        end else begin
            if (clr_rst_stall) rst_stall <= 1'b0;
            if (flush) begin
                flush_stall <= 1'b1;   // a new flush wins over the clear.
            end else if (clr_flush_stall) begin
                flush_stall <= 1'b0;
            end
            if (incr_walk_set) walk_set <= walk_set + 1'b1;   // wraps to 0 at the end.
        end
    end

    // ==================================================
    // missed request
    // ==================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_stall    <= 1'b0;
            parked_valid <= 1'b0;
        end else begin
            if (park) begin
                req_stall <= 1'b1;
            end else if (clr_req_stall) begin
                req_stall <= 1'b0;
            end
            // ready for replay once the fill has landed.
            if (clr_req_stall) begin
                parked_valid <= 1'b1;
            end else if (replay_taken) begin
                parked_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (park) begin
            parked_line <= park_line;
            parked_id   <= park_id;
        end
    end

    assign busy = rst_stall || flush_stall;

endmodule

`default_nettype wire

// ==== rtl/llc_tag_array.sv ====
`include "llc_defines.svh"
`default_nettype none

module llc_tag_array (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               look,
    input  wire logic               walk_clear,
    input  wire llc_pkg::llc_line_t line,
    input  wire llc_pkg::llc_src_t  src,
    input  wire logic [3:0]         id,
    input  wire logic               lkp_ready,
    output logic                    hit,
    output logic                    lkp_valid,
    output llc_pkg::llc_lkp_res_t   lkp_res,
    output logic                    lkp_busy
);

    import llc_pkg::*;

    localparam int unsigned NUM_SETS = 1 << `LLC_SET_BITS;

    llc_tag_t            tag_mem [NUM_SETS];
    logic [NUM_SETS-1:0] line_valid;   // cleared by the reset walk.
    logic                lookup_hit;
    logic                fill;

    assign fill       = look && (src == SRC_RSP);
    assign lookup_hit = line_valid[line.set] && (tag_mem[line.set] == line.tag);

    always_ff @(posedge clk) begin
        if (fill) tag_mem[line.set] <= line.tag;
    end

    always_ff @(posedge clk) begin
        if (walk_clear) begin
            line_valid[line.set] <= 1'b0;
        end else if (fill) begin
            line_valid[line.set] <= 1'b1;
        end
    end

    // ==================================================
    // result register
    // ==================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lkp_valid <= 1'b0;
        end else if (look) begin
            lkp_valid <= 1'b1;
        end else if (lkp_ready) begin
            lkp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (look) begin
            lkp_res.src <= src;
            lkp_res.hit <= lookup_hit;
            lkp_res.set <= line.set;
            lkp_res.tag <= line.tag;
            lkp_res.id  <= id;
        end
    end

    assign hit      = lkp_res.hit;
    assign lkp_busy = lkp_valid && !lkp_ready;   // keeps the round in STALL.

endmodule

`default_nettype wire

// ==== tb/llc_front_assertions.sv ====
`include "llc_defines.svh"
`default_nettype none

module llc_front_assertions (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  flush,
    input wire logic                  busy,
    input wire logic                  lkp_valid,
    input wire logic                  lkp_ready,
    input wire llc_pkg::llc_lkp_res_t lkp_res,
    input wire logic                  rsp_valid,
    input wire logic                  req_valid,
    input wire logic [1:0]            round_state
);

    timeunit 1ns;
    timeprecision 1ps;

    import llc_pkg::*;

    localparam logic [1:0]  ST_DECODE = 2'b01;
    localparam int unsigned NUM_SETS  = 1 << `LLC_SET_BITS;

    int unsigned         err_count = 0;
    logic [NUM_SETS-1:0] shadow_valid;
    llc_tag_t            shadow_tag [NUM_SETS];
    logic                stalled, replay_due, replay_hit;
    llc_set_t            stall_set;
    llc_tag_t            stall_tag;
    logic [3:0]          stall_id;
    logic                accepted, exp_hit;

    assign accepted = lkp_valid && lkp_ready;
    assign exp_hit  = shadow_valid[lkp_res.set] && (shadow_tag[lkp_res.set] == lkp_res.tag);

    // ==================================================
    // shadow tag table and parked request
    // ==================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            shadow_valid <= '0;
            stalled      <= 1'b0;
            replay_due   <= 1'b0;
            replay_hit   <= 1'b0;
        end else if (flush) begin
            shadow_valid <= '0;   // the flush walk clears every set.
        end else if (accepted) begin
            if (lkp_res.src == SRC_RSP) begin
                shadow_valid[lkp_res.set] <= 1'b1;
                shadow_tag[lkp_res.set]   <= lkp_res.tag;
                if (stalled && lkp_res.set == stall_set && lkp_res.tag == stall_tag) begin
                    stalled    <= 1'b0;
                    replay_due <= 1'b1;
                    replay_hit <= 1'b1;
                end else if (replay_due && lkp_res.set == stall_set) begin
                    replay_hit <= (lkp_res.tag == stall_tag);   // set refilled first.
                end
            end else begin
                if (lkp_res.src == SRC_REPLAY) replay_due <= 1'b0;
                if (!lkp_res.hit) begin
                    stalled   <= 1'b1;
                    stall_set <= lkp_res.set;
                    stall_tag <= lkp_res.tag;
                    stall_id  <= lkp_res.id;
                end
            end
        end
    end

    // ==================================================
    // checks
    // ==================================================
    a_busy_quiet: assert property (@(posedge clk) disable iff (!rst)
        busy |-> !lkp_valid)
        else begin
            $error("a lookup result was presented during an invalidate walk");
            err_count++;
        end

    a_hit_shadow: assert property (@(posedge clk) disable iff (!rst)
        accepted |-> lkp_res.hit == exp_hit)
        else begin
            $error("Error at %0t: lkp_res.hit = %0b, expected %0b",
                   $time, $sampled(lkp_res.hit), $sampled(exp_hit));
            err_count++;
        end

    // only responses pass while a request is parked.
    a_stall_blocks: assert property (@(posedge clk) disable iff (!rst)
        lkp_valid && stalled |-> lkp_res.src == SRC_RSP)
        else begin
            $error("a request or DMA result came out while a missed request was parked");
            err_count++;
        end

    a_replay_next: assert property (@(posedge clk) disable iff (!rst)
        lkp_valid && replay_due && lkp_res.src != SRC_RSP
        |-> lkp_res.src == SRC_REPLAY && lkp_res.id == stall_id && lkp_res.hit == replay_hit
            && lkp_res.set == stall_set && lkp_res.tag == stall_tag)
        else begin
            $error(
                "Error at %0t: lkp_res src/id/hit/line %0d/%0d/%0b/%0h, expected %0d/%0d/%0b/%0h",
                $time, $sampled(lkp_res.src), $sampled(lkp_res.id), $sampled(lkp_res.hit),
                $sampled({lkp_res.tag, lkp_res.set}), SRC_REPLAY, $sampled(stall_id),
                $sampled(replay_hit), $sampled({stall_tag, stall_set}));
            err_count++;
        end

    a_rsp_first: assert property (@(posedge clk) disable iff (!rst)
        round_state == ST_DECODE && rsp_valid && req_valid && !busy
        |-> ##2 lkp_valid && lkp_res.src == SRC_RSP)
        else begin
            $error("a waiting response lost the decision to a waiting request");
            err_count++;
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst)
        lkp_valid && !lkp_ready |=> lkp_valid && $stable(lkp_res))
        else begin
            $error("the result changed or dropped before it was accepted");
            err_count++;
        end

    a_single: assert property (@(posedge clk) disable iff (!rst)
        accepted |=> !lkp_valid)
        else begin
            $error("a result was presented twice or a second one followed without a round");
            err_count++;
        end

endmodule

bind llc_front llc_front_assertions chk_i (
    .clk(clk), .rst(rst), .flush(flush), .busy(busy),
    .lkp_valid(lkp_valid), .lkp_ready(lkp_ready), .lkp_res(lkp_res),
    .rsp_valid(rsp_valid), .req_valid(req_valid),
    .round_state(decoder_i.state)
);

`default_nettype wire

// ==== tb/llc_front_tb.sv ====
`include "llc_defines.svh"
`default_nettype none

module llc_front_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import llc_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 34162;
    localparam int WALK_CYCLES  = 4 * (1 << `LLC_SET_BITS);
    localparam int PER_CHANNEL  = 40;   // random items per channel and phase.
    localparam int ROUND_BOUND  = 16;   // one round with ready stalls.
    localparam int HOLD_CYCLES  = 40;
    // two phases, each item may add a fill and a replay.
    localparam int MAX_CYCLES   = RESET_CYCLES + 2 * WALK_CYCLES + HOLD_CYCLES
                                  + 2 * 3 * (3 * PER_CHANNEL) * ROUND_BOUND;

    logic         clk = 1'b0;
    logic         rst;
    logic         flush;
    logic         rsp_in_valid, req_in_valid, dma_in_valid;
    logic         rsp_in_ready, req_in_ready, dma_in_ready;
    llc_rsp_t     rsp_in_data;
    llc_req_t     req_in_data;
    llc_dma_t     dma_in_data;
    logic         lkp_valid, lkp_ready, busy;
    llc_lkp_res_t lkp_res;

    int unsigned  rsp_left = 0, req_left = 0, dma_left = 0;
    int unsigned  issued = 0, accepted = 0, replays = 0;
    logic         hold_ready = 1'b0;
    llc_addr_t    fill_q [$];
    llc_addr_t    rsp_sent_q [$];
    llc_req_t     req_sent_q [$];
    llc_addr_t    dma_sent_q [$];

    llc_front dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic llc_addr_t make_addr(input logic [31:0] r);
        llc_tag_t tag;
        llc_set_t set;
        tag      = '0;
        set      = '0;
        tag[1:0] = r[1:0];   // four tags and four sets, so lines repeat.
        set[1:0] = r[3:2];
        return {tag, set, r[4 +: `LLC_OFFSET_BITS]};
    endfunction

    // ==================================================
    // channel drivers
    // ==================================================
    task automatic send_rsp(input llc_addr_t addr);
        @(posedge clk);
        rsp_in_valid     <= 1'b1;
        rsp_in_data.addr <= addr;
        do @(posedge clk); while (!rsp_in_ready);
        rsp_in_valid <= 1'b0;
        rsp_sent_q.push_back(addr);
    endtask

    task automatic send_req(input llc_addr_t addr, input logic [3:0] id);
        @(posedge clk);
        req_in_valid <= 1'b1;
        req_in_data  <= '{addr: addr, id: id};
        do @(posedge clk); while (!req_in_ready);
        req_in_valid <= 1'b0;
        req_sent_q.push_back('{addr: addr, id: id});
    endtask

    task automatic send_dma(input llc_addr_t addr, input logic write);
        @(posedge clk);
        dma_in_valid <= 1'b1;
        dma_in_data  <= '{addr: addr, write: write};
        do @(posedge clk); while (!dma_in_ready);
        dma_in_valid <= 1'b0;
        dma_sent_q.push_back(addr);
    endtask

    initial begin : rsp_traffic
        logic [31:0] r;
        r = SEED + 1;
        forever begin
            @(negedge clk);
            if (fill_q.size() > 0) begin
                issued++;
                send_rsp(fill_q.pop_front());   // refill for a parked miss.
            end else if (rsp_left > 0) begin
                rsp_left--;
                issued++;
                r = xorshift(r);
                send_rsp(make_addr(r));
                repeat (r[9:8]) @(negedge clk);
            end
        end
    end

    initial begin : req_traffic
        logic [31:0] r;
        r = SEED + 2;
        forever begin
            @(negedge clk);
            if (req_left > 0) begin
                req_left--;
                issued++;
                r = xorshift(r);
                send_req(make_addr(r), r[13:10]);
                repeat (r[9:8]) @(negedge clk);
            end
        end
    end

    initial begin : dma_traffic
        logic [31:0] r;
        r = SEED + 3;
        forever begin
            @(negedge clk);
            if (dma_left > 0) begin
                dma_left--;
                issued++;
                r = xorshift(r);
                send_dma(make_addr(r), r[10]);
                repeat (r[9:8]) @(negedge clk);
            end
        end
    end

    initial begin : ready_driver
        logic [31:0] r;
        r = SEED + 4;
        forever begin
            @(posedge clk);
            r = xorshift(r);
            if (rst) lkp_ready <= !hold_ready && (r[1:0] != 2'b00);
        end
    end

    // ==================================================
    // result contents
    // ==================================================
    task automatic abort_run(input string reason);
        $display("Test FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_mismatch(input string name, input int unsigned got,
                                   input int unsigned exp);
        $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        abort_run("a lookup result does not match the item that was sent");
    endtask

    // address layout is {tag, set, offset}.
    task automatic compare_line(input llc_addr_t addr);
        llc_tag_t exp_tag;
        llc_set_t exp_set;
        exp_tag = addr[`LLC_ADDR_BITS-1 -: `LLC_TAG_BITS];
        exp_set = addr[`LLC_OFFSET_BITS +: `LLC_SET_BITS];
        assert (lkp_res.tag == exp_tag)
            else report_mismatch("lkp_res.tag", lkp_res.tag, exp_tag);
        assert (lkp_res.set == exp_set)
            else report_mismatch("lkp_res.set", lkp_res.set, exp_set);
    endtask

    // each channel's results come out in the order its items were accepted.
    task automatic check_result();
        llc_req_t req;
        case (lkp_res.src)
            SRC_RSP: begin
                assert (rsp_sent_q.size() != 0)
                    else abort_run("a response result came out with no response pending");
                compare_line(rsp_sent_q.pop_front());
            end
            SRC_REQ: begin
                assert (req_sent_q.size() != 0)
                    else abort_run("a request result came out with no request pending");
                req = req_sent_q.pop_front();
                compare_line(req.addr);
                assert (lkp_res.id == req.id)
                    else report_mismatch("lkp_res.id", lkp_res.id, req.id);
            end
            SRC_DMA: begin
                assert (dma_sent_q.size() != 0)
                    else abort_run("a DMA result came out with no DMA request pending");
                compare_line(dma_sent_q.pop_front());
            end
            default: ;   // replays are checked against the parked request.
        endcase
    endtask

    // a missed request waits for a fill of its line, then replays.
    always @(posedge clk) begin
        if (rst && lkp_valid && lkp_ready) begin
            accepted++;
            check_result();
            if (lkp_res.src != SRC_RSP && !lkp_res.hit) begin
                replays++;
                fill_q.push_back({lkp_res.tag, lkp_res.set, {`LLC_OFFSET_BITS{1'b0}}});
            end
        end
    end

    always @(negedge clk) begin
        if (dut_i.chk_i.err_count != 0) begin
            $display("Test FAILED");
            $fatal(1, "an assertion in the bound checker failed");
        end
    end

    initial begin : watchdog
        #(MAX_CYCLES * CLK_PERIOD);
        $display("Test FAILED");
        $fatal(1, "watchdog expired after %0d cycles with traffic still pending", MAX_CYCLES);
    end

    // ==================================================
    // test sequence
    // ==================================================
    task automatic run_phase(input int unsigned n);
        @(posedge clk);
        rsp_left = n;
        req_left = n;
        dma_left = n;
        do @(negedge clk);
        while (rsp_left + req_left + dma_left != 0 || fill_q.size() != 0
               || accepted != issued + replays);
    endtask

    initial begin : main
        rst          = 1'b0;
        flush        = 1'b0;
        rsp_in_valid = 1'b0;
        req_in_valid = 1'b0;
        dma_in_valid = 1'b0;
        rsp_in_data  = '0;
        req_in_data  = '0;
        dma_in_data  = '0;
        lkp_ready    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;

        hold_ready = 1'b1;   // first results wait at the output.
        fork
            begin
                do @(negedge clk); while (busy);   // power-on walk.
                repeat (HOLD_CYCLES) @(negedge clk);
                hold_ready = 1'b0;
            end
        join_none
        run_phase(PER_CHANNEL);   // items queue up behind the walk.

        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        run_phase(PER_CHANNEL);   // and behind the flush walk.

        repeat (4) @(posedge clk);
        if (dut_i.chk_i.err_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "the bound checker recorded %0d failures", dut_i.chk_i.err_count);
        end
    end

endmodule

`default_nettype wire
